//--- Makefile
# Verilator run of the host loader testbench

sim:
	verilator --binary --timing --timescale 1ns/100ps -f build.f --top-module tb_loader -o sim_loader
	@out="$$(./obj_dir/sim_loader)"; echo "$$out"; echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf obj_dir

.PHONY: sim clean

//--- build.f
design/loader_pkg.sv
design/download_decode.sv
design/word_packer.sv
design/cheat_assembler.sv
design/loader_top.sv
test/loader_checker.sv
test/tb_loader.sv

//--- design/cheat_assembler.sv
// Collects the halfwords of a cheat download into 128-bit cheat records and flags each record
module cheat_assembler (
	input  logic                    clk_1x,
	input  logic                    rst_n,
	input  loader_pkg::host_bus_t   host,
	input  loader_pkg::dl_kind_t    kind,
	input  logic                    code_start,
	output loader_pkg::cheat_code_t cheat,
	output logic                    cheat_valid,
	output logic                    cheat_clear
);

	import loader_pkg::*;

	logic       code_wr;
	logic [3:0] offset;
	logic       last_half;

	assign code_wr   = (kind == CODE) && host.wr;
	assign offset    = host.addr[3:0];

	// Top half of replace closes the record
	assign last_half = (offset == 4'(2 * (CHEAT_HALVES - 1)));

	// ======================================================================
	// Record assembly
	// ======================================================================

	always_ff @(posedge clk_1x or negedge rst_n) begin
		if (!rst_n) begin
			cheat       <= '0;
			cheat_valid <= 1'b0;
			cheat_clear <= 1'b0;
		end else begin
			cheat_clear <= code_start;
			cheat_valid <= code_wr && last_half;

			if (code_wr) begin
				// Bottom half first, then top half, per field
				case (offset)
					4'd0:  cheat.flags[15:0]    <= host.data;
					4'd2:  cheat.flags[31:16]   <= host.data;
					4'd4:  cheat.addr[15:0]     <= host.data;
					4'd6:  cheat.addr[31:16]    <= host.data;
					4'd8:  cheat.compare[15:0]  <= host.data;
					4'd10: cheat.compare[31:16] <= host.data;
					4'd12: cheat.replace[15:0]  <= host.data;
					4'd14: cheat.replace[31:16] <= host.data;
					// Odd offsets never come from the host
					default: ;
				endcase
			end
		end
	end

endmodule

//--- design/download_decode.sv
// Decodes the host download index into a registered download kind with start and end strobes
module download_decode (
	input  logic                  clk_1x,
	input  logic                  rst_n,
	input  loader_pkg::host_bus_t host,
	output loader_pkg::dl_kind_t  kind,
	output logic                  exe_done,
	output logic                  code_start
);

	import loader_pkg::*;

	dl_kind_t kind_next;
	dl_kind_t kind_prev;

	// ======================================================================
	// Index decode
	// ======================================================================

	// Unknown indices fall through to NONE
	always_comb begin
		kind_next = NONE;
		if (host.download) begin
			case (host.index)
				IDX_BIOS: kind_next = BIOS;
				IDX_EXE:  kind_next = EXE;
				IDX_CODE: kind_next = CODE;
				default:  kind_next = NONE;
			endcase
		end
	end

	// ======================================================================
	// Kind register and edge detect
	// ======================================================================

	always_ff @(posedge clk_1x or negedge rst_n) begin
		if (!rst_n) begin
			kind      <= NONE;
			kind_prev <= NONE;
			exe_done  <= 1'b0;
		end else begin
			kind      <= kind_next;
			kind_prev <= kind;
			// End of an EXE image, one cycle after kind drops
			exe_done  <= (kind_prev == EXE) && (kind != EXE);
		end
	end

	// First cycle of a cheat download
	assign code_start = (kind == CODE) && (kind_prev != CODE);

endmodule

//--- design/loader_pkg.sv
// Shared widths, RAM base addresses, download indices and bus types, imported by all loader files
package loader_pkg;

	// ======================================================================
	// Widths
	// ======================================================================

	localparam int HOST_ADDR_W = 27;
	localparam int HALF_W      = 16;
	localparam int WORD_W      = 32;
	localparam int IDX_W       = 8;

	// ======================================================================
	// Download indices and RAM targets
	// ======================================================================

	localparam logic [IDX_W-1:0] IDX_BIOS = 8'd0;
	localparam logic [IDX_W-1:0] IDX_EXE  = 8'd1;
	localparam logic [IDX_W-1:0] IDX_CODE = 8'd255;

	// Byte addresses in main RAM
	localparam logic [HOST_ADDR_W-1:0] BIOS_BASE = 27'd2097152;
	localparam logic [HOST_ADDR_W-1:0] EXE_BASE  = 27'd4194304;

	// Write credits granted by the memory side after reset
	localparam int MEM_CREDITS = 2;
	localparam int CREDIT_W    = 2;

	// Halfwords per cheat record
	localparam int CHEAT_HALVES = 8;

	// ======================================================================
	// Types
	// ======================================================================

	// Host download bus, one halfword per wr cycle
	typedef struct packed {
		logic                   download;
		logic [IDX_W-1:0]       index;
		logic                   wr;
		logic [HOST_ADDR_W-1:0] addr;
		logic [HALF_W-1:0]      data;
	} host_bus_t;

	typedef enum logic [1:0] {
		NONE,
		BIOS,
		EXE,
		CODE
	} dl_kind_t;

	// Full-word write toward the RAM
	typedef struct packed {
		logic                   valid;
		logic [HOST_ADDR_W-1:0] addr;
		logic [WORD_W-1:0]      data;
	} ram_wr_t;

	// Flags sit in the top 32 bits
	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] addr;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

endpackage

//--- design/loader_top.sv
// Top level of the host loader, joining the kind decoder, RAM word packer and cheat assembler
module loader_top (
	input  logic                    clk_1x,
	input  logic                    rst_n,
	input  loader_pkg::host_bus_t   host,
	input  logic                    credit_return,
	output loader_pkg::ram_wr_t     ram_wr,
	output logic                    ioctl_wait,
	output logic                    load_exe,
	output loader_pkg::cheat_code_t cheat,
	output logic                    cheat_valid,
	output logic                    cheat_clear
);

	import loader_pkg::*;

	dl_kind_t kind;
	logic     code_start;

	// ======================================================================
	// Download kind
	// ======================================================================

	download_decode u_decode (
		.clk_1x     (clk_1x),
		.rst_n      (rst_n),
		.host       (host),
		.kind       (kind),
		.exe_done   (load_exe),
		.code_start (code_start)
	);

	// ======================================================================
	// BIOS and EXE images to RAM
	// ======================================================================

	word_packer u_packer (
		.clk_1x        (clk_1x),
		.rst_n         (rst_n),
		.host          (host),
		.kind          (kind),
		.credit_return (credit_return),
		.ram_wr        (ram_wr),
		.ioctl_wait    (ioctl_wait)
	);

	// ======================================================================
	// Cheat records
	// ======================================================================

	cheat_assembler u_cheat (
		.clk_1x      (clk_1x),
		.rst_n       (rst_n),
		.host        (host),
		.kind        (kind),
		.code_start  (code_start),
		.cheat       (cheat),
		.cheat_valid (cheat_valid),
		.cheat_clear (cheat_clear)
	);

endmodule

//--- design/word_packer.sv
// Pairs host halfwords into 32-bit RAM writes at a per-kind base and throttles the host by credits
module word_packer (
	input  logic                  clk_1x,
	input  logic                  rst_n,
	input  loader_pkg::host_bus_t host,
	input  loader_pkg::dl_kind_t  kind,
	input  logic                  credit_return,
	output loader_pkg::ram_wr_t   ram_wr,
	output logic                  ioctl_wait
);

	import loader_pkg::*;

	logic                   ram_kind;
	logic                   lo_wr;
	logic                   hi_wr;
	logic                   credit_ok;
	logic                   issue;
	logic [HOST_ADDR_W-1:0] base_addr;

	logic [HALF_W-1:0]      lo_data;
	logic [HOST_ADDR_W-1:0] lo_addr;
	logic [WORD_W-1:0]      word_data;
	logic [HOST_ADDR_W-1:0] word_addr;
	logic                   word_valid;
	logic [CREDIT_W-1:0]    credits;

	// ======================================================================
	// Halfword classification
	// ======================================================================

	// Only BIOS and EXE images go to RAM
	assign ram_kind  = (kind == BIOS) || (kind == EXE);
	assign lo_wr     = ram_kind && host.wr && !host.addr[1];
	assign hi_wr     = ram_kind && host.wr && host.addr[1];
	assign base_addr = (kind == BIOS) ? BIOS_BASE : EXE_BASE;

	// A credit returned this cycle counts as available
	assign credit_ok = (credits != '0) || credit_return;

	// Issue straight from the bus, or release the held word
	assign issue = credit_ok && (hi_wr || ioctl_wait);

	// ======================================================================
	// Word assembly
	// ======================================================================

	always_ff @(posedge clk_1x) begin
		if (lo_wr) begin
			lo_data <= host.data;
			lo_addr <= host.addr + base_addr;
		end
		// High half completes the word, held here if no credit
		if (hi_wr) begin
			word_data <= {host.data, lo_data};
			word_addr <= lo_addr;
		end
	end

	// ======================================================================
	// Credits and host stall
	// ======================================================================

	always_ff @(posedge clk_1x or negedge rst_n) begin
		if (!rst_n) begin
			word_valid <= 1'b0;
			ioctl_wait <= 1'b0;
			credits    <= CREDIT_W'(MEM_CREDITS);
		end else begin
			word_valid <= issue;

			if (issue) begin
				ioctl_wait <= 1'b0;
			end else if (hi_wr) begin
				ioctl_wait <= 1'b1;
			end

			// One credit per issued write, one back per return
			credits <= credits - CREDIT_W'(word_valid) + CREDIT_W'(credit_return);
		end
	end

	assign ram_wr = '{valid: word_valid, addr: word_addr, data: word_data};

endmodule

//--- test/loader_checker.sv
// Watches the loader ports, predicts RAM writes, strobes and cheat records, and counts mismatches
module loader_checker (
	input  logic                    clk_1x,
	input  logic                    rst_n,
	input  loader_pkg::host_bus_t   host,
	input  logic                    credit_return,
	input  loader_pkg::ram_wr_t     ram_wr,
	input  logic                    ioctl_wait,
	input  logic                    load_exe,
	input  loader_pkg::cheat_code_t cheat,
	input  logic                    cheat_valid,
	input  logic                    cheat_clear,
	input  logic                    test_done,
	input  int                      test_num,
	output logic                    idle,
	output int                      error_count,
	output int                      tests_failed
);

	timeunit 1ns;
	timeprecision 100ps;

	import loader_pkg::*;

	typedef struct packed {
		logic [HOST_ADDR_W-1:0] addr;
		logic [WORD_W-1:0]      data;
	} word_t;

	word_t                  words_q[$];
	word_t                  word;
	dl_kind_t               kind_now;
	dl_kind_t               kind_last;
	logic [HALF_W-1:0]      lo_data;
	logic [HOST_ADDR_W-1:0] lo_addr;
	cheat_code_t            cheat_model;
	cheat_code_t            cheat_expect;
	logic                   issue_due;
	logic                   wait_due;
	logic                   exe_due;
	logic                   clear_due;
	logic                   cheat_due;
	logic                   avail;
	int                     outstanding;
	int                     reset_cycles;
	int                     test_errors;
	int                     half_idx;

	// Download kind as the host bus announces it
	function automatic dl_kind_t kind_of(input host_bus_t h);
		if (!h.download) return NONE;
		if (h.index == IDX_BIOS) return BIOS;
		if (h.index == IDX_EXE) return EXE;
		if (h.index == IDX_CODE) return CODE;
		return NONE;
	endfunction

	task automatic report_mismatch(input string msg);
		$display("Mismatch at %0d ns: %s", $time, msg);
		error_count++;
		test_errors++;
	endtask

	// ======================================================================
	// Compare and predict once per cycle at the falling edge
	// ======================================================================

	always @(negedge clk_1x) begin
		if (!rst_n) begin
			reset_cycles++;
			// Give the first rising edge time to clear the registers
			if (reset_cycles > 1 && ({ram_wr.valid, ioctl_wait, load_exe, cheat_valid,
				cheat_clear} !== '0 || cheat !== '0)) begin
				report_mismatch("outputs not at their reset values during reset");
			end
			words_q.delete();
			outstanding = 0;
			issue_due   = 1'b0;
			wait_due    = 1'b0;
			exe_due     = 1'b0;
			clear_due   = 1'b0;
			cheat_due   = 1'b0;
			kind_now    = NONE;
			kind_last   = NONE;
			cheat_model = '0;
			idle        = 1'b0;
		end else begin
			if (ram_wr.valid !== issue_due) begin
				report_mismatch($sformatf("ram_wr.valid is %0b, expected %0b",
					ram_wr.valid, issue_due));
			end
			if (ram_wr.valid) begin
				if (words_q.size() == 0) begin
					report_mismatch("RAM write issued with no word expected");
				end else begin
					word = words_q.pop_front();
					if (ram_wr.addr !== word.addr || ram_wr.data !== word.data) begin
						report_mismatch($sformatf("RAM write %h <= %h, expected %h <= %h",
							ram_wr.addr, ram_wr.data, word.addr, word.data));
					end
				end
			end
			if (ioctl_wait !== wait_due)
				report_mismatch($sformatf("ioctl_wait is %0b, expected %0b", ioctl_wait, wait_due));
			if (load_exe !== exe_due)
				report_mismatch($sformatf("load_exe is %0b, expected %0b", load_exe, exe_due));
			if (cheat_clear !== clear_due)
				report_mismatch($sformatf("cheat_clear is %0b, expected %0b", cheat_clear, clear_due));
			if (cheat_valid !== cheat_due)
				report_mismatch($sformatf("cheat_valid is %0b, expected %0b", cheat_valid, cheat_due));
			if (cheat_valid && cheat !== cheat_expect)
				report_mismatch($sformatf("cheat %h, expected %h", cheat, cheat_expect));

			// Credit state seen by a high half arriving now
			avail = (outstanding < MEM_CREDITS) || credit_return;
			outstanding = outstanding + int'(ram_wr.valid) - int'(credit_return);
			if (outstanding > MEM_CREDITS || outstanding < 0)
				report_mismatch($sformatf("%0d RAM writes outstanding", outstanding));

			if ((kind_now == BIOS || kind_now == EXE) && host.wr) begin
				if (host.addr[1] == 1'b0) begin
					lo_data = host.data;
					lo_addr = host.addr + ((kind_now == BIOS) ? BIOS_BASE : EXE_BASE);
				end else begin
					word.addr = lo_addr;
					word.data = {host.data, lo_data};
					words_q.push_back(word);
				end
			end
			issue_due = (words_q.size() != 0) && avail;
			wait_due  = (words_q.size() != 0) && !avail;

			// Records fill flags first and each field bottom half first
			cheat_due = 1'b0;
			if (kind_now == CODE && host.wr) begin
				half_idx = int'(host.addr[3:1]);
				cheat_model[96 - 32 * (half_idx / 2) + 16 * (half_idx % 2) +: HALF_W] = host.data;
				if (half_idx == CHEAT_HALVES - 1) begin
					cheat_expect = cheat_model;
					cheat_due    = 1'b1;
				end
			end

			clear_due = (kind_now == CODE) && (kind_last != CODE);
			exe_due   = (kind_last == EXE) && (kind_now != EXE);
			kind_last = kind_now;
			kind_now  = kind_of(host);

			idle = (words_q.size() == 0) && (outstanding == 0) && !issue_due && !wait_due
				&& !exe_due && !clear_due && !cheat_due;
		end

		if (test_done) begin
			if (test_errors == 0) begin
				$display("Test %0d passed", test_num);
			end else begin
				$display("Test %0d failed with %0d mismatches", test_num, test_errors);
				tests_failed++;
			end
			test_errors = 0;
		end
	end

endmodule

//--- test/loader_testdata.txt
# Block: test <download index> <credit delay, 0 means random 1 to 8 cycles>
# Lines: h <byte address hex> <halfword hex>, each block closed by end
# BIOS image, three words
test 0 0
h 0000000 1111
h 0000002 a0a0
h 0000004 2222
h 0000006 b0b0
h 0000008 3333
h 000000a c0c0
end
# EXE image, load_exe after the end
test 1 0
h 0000100 0800
h 0000102 3c1d
h 0000104 27bd
h 0000106 fff0
end
# BIOS with slow credit return, host gets stalled
test 0 12
h 0000040 0001
h 0000042 1000
h 0000044 0002
h 0000046 2000
h 0000048 0003
h 000004a 3000
h 000004c 0004
h 000004e 4000
end
# Two cheat records
test 255 0
h 0000000 0001
h 0000002 9000
h 0000004 1234
h 0000006 8001
h 0000008 00ff
h 000000a 0000
h 000000c 5678
h 000000e 0000
h 0000010 0002
h 0000012 a000
h 0000014 4321
h 0000016 8002
h 0000018 0000
h 000001a 0000
h 000001c 8765
h 000001e 0001
end
# Unknown index, nothing expected
test 7 0
h 0000000 dead
h 0000002 beef
end

//--- test/tb_loader.sv
// Testbench top for the host loader, running file-driven downloads against a credit-returning memory
module tb_loader;

	timeunit 1ns;
	timeprecision 100ps;

	import loader_pkg::*;

	localparam int WAIT_LIMIT  = 200;
	localparam int DRAIN_LIMIT = 400;
	localparam int RUN_LIMIT   = 20000;

	logic        clk_1x;
	logic        rst_n;
	host_bus_t   host;
	logic        credit_return;
	ram_wr_t     ram_wr;
	logic        ioctl_wait;
	logic        load_exe;
	cheat_code_t cheat;
	logic        cheat_valid;
	logic        cheat_clear;

	logic        test_done;
	int          test_num;
	logic        idle;
	int          error_count;
	int          tests_failed;
	int          run_errors;

	int          seed;
	int          long_delay;
	int          cycle;
	int          due_q[$];

	initial clk_1x = 1'b0;
	always #2 clk_1x = ~clk_1x;

	loader_top dut (
		.clk_1x        (clk_1x),
		.rst_n         (rst_n),
		.host          (host),
		.credit_return (credit_return),
		.ram_wr        (ram_wr),
		.ioctl_wait    (ioctl_wait),
		.load_exe      (load_exe),
		.cheat         (cheat),
		.cheat_valid   (cheat_valid),
		.cheat_clear   (cheat_clear)
	);

	loader_checker monitor (
		.clk_1x        (clk_1x),
		.rst_n         (rst_n),
		.host          (host),
		.credit_return (credit_return),
		.ram_wr        (ram_wr),
		.ioctl_wait    (ioctl_wait),
		.load_exe      (load_exe),
		.cheat         (cheat),
		.cheat_valid   (cheat_valid),
		.cheat_clear   (cheat_clear),
		.test_done     (test_done),
		.test_num      (test_num),
		.idle          (idle),
		.error_count   (error_count),
		.tests_failed  (tests_failed)
	);

	// ======================================================================
	// Memory side returning one credit per write after a delay
	// ======================================================================

	function automatic int next_delay();
		if (long_delay > 0) return long_delay;
		return $random(seed) & 7;
	endfunction

	always @(posedge clk_1x) begin
		#1;
		cycle++;
		credit_return = 1'b0;
		if (!rst_n) begin
			due_q.delete();
		end else begin
			if (due_q.size() != 0 && due_q[0] <= cycle) begin
				credit_return = 1'b1;
				void'(due_q.pop_front());
			end
			if (ram_wr.valid)
				due_q.push_back(cycle + 1 + next_delay());
		end
	end

	// ======================================================================
	// Host side
	// ======================================================================

	task automatic start_download(input logic [IDX_W-1:0] idx);
		host.download = 1'b1;
		host.index    = idx;
		host.wr       = 1'b0;
		// Kind settles one cycle later
		repeat (2) @(posedge clk_1x);
		#1;
	endtask

	task automatic send_half(input logic [HOST_ADDR_W-1:0] addr, input logic [HALF_W-1:0] data);
		int spins;
		spins = 0;
		while (ioctl_wait && spins < WAIT_LIMIT) begin
			@(posedge clk_1x);
			#1;
			spins++;
		end
		if (ioctl_wait) begin
			$display("Timeout: ioctl_wait high for %0d cycles, halfword at %h not sent",
				WAIT_LIMIT, addr);
			run_errors++;
		end else begin
			host.wr   = 1'b1;
			host.addr = addr;
			host.data = data;
			@(posedge clk_1x);
			#1;
			host.wr = 1'b0;
		end
	endtask

	// Drop the download, let writes and credits drain, then close the test
	task automatic finish_download();
		int spins;
		host = '0;
		repeat (4) @(posedge clk_1x);
		#1;
		spins = 0;
		while (!idle && spins < DRAIN_LIMIT) begin
			@(posedge clk_1x);
			#1;
			spins++;
		end
		if (!idle) begin
			$display("Timeout: test %0d still had writes, credits or strobes pending", test_num);
			run_errors++;
		end
		test_done = 1'b1;
		@(posedge clk_1x);
		#1;
		test_done  = 1'b0;
		long_delay = 0;
	endtask

	initial begin
		int               fd;
		int               r;
		string            tok;
		logic [IDX_W-1:0] idx;
		int               delay;
		logic [HOST_ADDR_W-1:0] addr;
		logic [HALF_W-1:0]      data;
		logic [8*100-1:0]       rest;

		seed          = 87;
		host          = '0;
		credit_return = 1'b0;
		rst_n         = 1'b0;
		test_done     = 1'b0;
		test_num      = 0;
		run_errors    = 0;
		long_delay    = 0;
		repeat (10) @(posedge clk_1x);
		#1;
		rst_n = 1'b1;
		repeat (2) @(posedge clk_1x);
		#1;

		fd = $fopen("test/loader_testdata.txt", "r");
		if (fd == 0) begin
			$display("Could not open test/loader_testdata.txt");
			run_errors++;
		end else begin
			while ($fscanf(fd, "%s", tok) == 1) begin
				if (tok == "#") begin
					r = $fgets(rest, fd);
				end else if (tok == "test") begin
					r = $fscanf(fd, "%d %d", idx, delay);
					if (r != 2) begin
						$display("Test line in test data lacks its index or delay");
						run_errors++;
					end
					long_delay = delay;
					test_num++;
					start_download(idx);
				end else if (tok == "h") begin
					r = $fscanf(fd, "%h %h", addr, data);
					if (r != 2) begin
						$display("Halfword line in test data lacks its address or data");
						run_errors++;
					end
					send_half(addr, data);
				end else if (tok == "end") begin
					finish_download();
				end else begin
					$display("Unknown token in test data: %s", tok);
					run_errors++;
				end
			end
			$fclose(fd);
		end

		repeat (4) @(posedge clk_1x);
		$display("%0d tests run, %0d failed, %0d mismatches, %0d other errors",
			test_num, tests_failed, error_count, run_errors);
		if (test_num > 0 && tests_failed == 0 && error_count == 0 && run_errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

	// Run limit for the whole simulation
	initial begin
		repeat (RUN_LIMIT) @(posedge clk_1x);
		$display("Run did not finish within %0d clock cycles", RUN_LIMIT);
		$display("TESTS FAILED");
		$finish;
	end

endmodule
